/* common/sdhci_consts.svh */
/* SD host controller constants
   Bus widths, SDHCI register offsets, bit positions and buffer/command timing */

`ifndef SDHCI_CONSTS_SVH
`define SDHCI_CONSTS_SVH

// Bus widths
`define SDHCI_AW 32
`define SDHCI_DW 32

// Register offsets in bytes, low address byte only
`define SDHCI_ARGUMENT      8'h08
`define SDHCI_COMMAND       8'h0C
`define SDHCI_BUFFER_DATA   8'h20
`define SDHCI_PRESENT_STATE 8'h24
`define SDHCI_INT_STATUS    8'h30
`define SDHCI_INT_ENABLE    8'h34

// Command register layout
`define SDHCI_CMD_IDX_MSB 13
`define SDHCI_CMD_IDX_LSB 8

// Present State bits
`define SDHCI_PS_CMD_INHIBIT 0
`define SDHCI_PS_BUF_WR_EN   10 // FIFO not full
`define SDHCI_PS_BUF_RD_EN   11 // FIFO not empty

// Interrupt Status bits
`define SDHCI_INT_CMD_COMPLETE 0

`define SDHCI_BUF_DEPTH   8
`define SDHCI_CMD_LATENCY 6

`endif

/* common/sdhci_pkg.sv */
/* SD host controller types
   OBI and register bus structs, plus the register file to hardware structs */

`include "sdhci_consts.svh"

package sdhci_pkg;

  // ================================================
  // OBI bus
  // ================================================
  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [`SDHCI_DW/8-1:0]    be;
    logic [`SDHCI_AW-1:0]      addr;
    logic [`SDHCI_DW-1:0]      wdata;
  } obi_req_t;

  typedef struct packed {
    logic                      gnt;
    logic                      rvalid;
    logic [`SDHCI_DW-1:0]      rdata;
    logic                      err;
  } obi_rsp_t;

  // ================================================
  // Register bus
  // ================================================
  typedef struct packed {
    logic                      valid;
    logic                      write;
    logic [`SDHCI_AW-1:0]      addr;
    logic [`SDHCI_DW-1:0]      wdata;
  } reg_req_t;

  typedef struct packed {
    logic [`SDHCI_DW-1:0]      rdata;
    logic                      error;
    logic                      ready;
  } reg_rsp_t;

  // ================================================
  // Register file <-> hardware
  // ================================================
  typedef struct packed {
    logic [`SDHCI_DW-1:0]      q;  // Word written to the data port
    logic                      qe; // Write strobe
    logic                      re; // Read strobe
  } sdhci_reg2hw_buffer_data_port_t;

  typedef struct packed {
    logic [`SDHCI_CMD_IDX_MSB-`SDHCI_CMD_IDX_LSB:0] q;
    logic                                          qe;
  } sdhci_reg2hw_command_index_t;

  typedef struct packed {
    sdhci_reg2hw_buffer_data_port_t buffer_data_port;
    sdhci_reg2hw_command_index_t    command_index;
  } sdhci_reg2hw_t;

  typedef struct packed {
    logic [`SDHCI_DW-1:0]      d;  // Head word of the buffer
  } sdhci_hw2reg_buffer_data_port_t;

  typedef struct packed {
    sdhci_hw2reg_buffer_data_port_t buffer_data_port;
    logic                           buffer_full;
    logic                           buffer_empty;
    logic                           command_inhibit_cmd;
    logic                           command_complete; // One-cycle pulse
  } sdhci_hw2reg_t;

endpackage

/* src/obi_to_reg.sv */
/* OBI to register bus adapter
   Grants one access at a time and returns the register answer one cycle later */

`timescale 1ns/1ps
`include "sdhci_consts.svh"

module obi_to_reg (
  input  logic                clk_i,
  input  logic                rst_i,
  input  sdhci_pkg::obi_req_t obi_req_i,
  output sdhci_pkg::obi_rsp_t obi_rsp_o,
  output sdhci_pkg::reg_req_t reg_req_o,
  input  sdhci_pkg::reg_rsp_t reg_rsp_i
);

  logic                 pending_q; // Response due in this cycle
  logic                 accept;
  logic                 partial_wr;
  logic [`SDHCI_DW-1:0] rdata_q;
  logic                 err_q;

  assign accept     = obi_req_i.req & ~pending_q;
  assign partial_wr = obi_req_i.we & (obi_req_i.be != '1); // Registers are word-wide only

  // Single-cycle register access on the accepting cycle
  assign reg_req_o.valid = accept & ~partial_wr;
  assign reg_req_o.write = obi_req_i.we;
  assign reg_req_o.addr  = obi_req_i.addr;
  assign reg_req_o.wdata = obi_req_i.wdata;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= obi_req_i.we ? '0 : reg_rsp_i.rdata;
      err_q   <= partial_wr | reg_rsp_i.error | ~reg_rsp_i.ready;
    end
  end

  assign obi_rsp_o.gnt    = ~pending_q;
  assign obi_rsp_o.rvalid = pending_q;
  assign obi_rsp_o.rdata  = rdata_q;
  assign obi_rsp_o.err    = err_q;

  // Every response answers a request granted one cycle before
  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    obi_rsp_o.rvalid |-> $past(obi_req_i.req && obi_rsp_o.gnt));

endmodule

/* sdhci_regs/sdhci_reg_file.sv */
/* SDHCI register map
   Offset decode, register storage, read mux, W1C interrupt status and interrupt line */

`timescale 1ns/1ps
`include "sdhci_consts.svh"

module sdhci_reg_file (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  sdhci_pkg::reg_req_t      reg_req_i,
  output sdhci_pkg::reg_rsp_t      reg_rsp_o,
  output sdhci_pkg::sdhci_reg2hw_t reg2hw_o,
  input  sdhci_pkg::sdhci_hw2reg_t hw2reg_i,
  output logic                     interrupt_o
);

  logic [7:0]           offset;
  logic                 wr;
  logic                 rd;
  logic [`SDHCI_DW-1:0] argument_q;
  logic [`SDHCI_DW-1:0] command_q;
  logic [`SDHCI_DW-1:0] int_enable_q;
  logic                 cmd_done_q;    // Interrupt Status bit 0
  logic [`SDHCI_DW-1:0] int_status;
  logic [`SDHCI_DW-1:0] present_state;
  logic                 irq_q;

  assign offset = reg_req_i.addr[7:0]; // Upper address bits select the block, not a register
  assign wr     = reg_req_i.valid & reg_req_i.write;
  assign rd     = reg_req_i.valid & ~reg_req_i.write;

  // ================================================
  // Status words
  // ================================================
  always_comb begin
    present_state = '0;
    present_state[`SDHCI_PS_CMD_INHIBIT] = hw2reg_i.command_inhibit_cmd;
    present_state[`SDHCI_PS_BUF_WR_EN]   = ~hw2reg_i.buffer_full;
    present_state[`SDHCI_PS_BUF_RD_EN]   = ~hw2reg_i.buffer_empty;
  end

  always_comb begin
    int_status = '0;
    int_status[`SDHCI_INT_CMD_COMPLETE] = cmd_done_q;
  end

  // ================================================
  // Read mux
  // ================================================
  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.ready = 1'b1;
    case (offset)
      `SDHCI_ARGUMENT:      reg_rsp_o.rdata = argument_q;
      `SDHCI_COMMAND:       reg_rsp_o.rdata = command_q;
      `SDHCI_BUFFER_DATA:   reg_rsp_o.rdata = hw2reg_i.buffer_data_port.d;
      `SDHCI_PRESENT_STATE: reg_rsp_o.rdata = present_state;
      `SDHCI_INT_STATUS:    reg_rsp_o.rdata = int_status;
      `SDHCI_INT_ENABLE:    reg_rsp_o.rdata = int_enable_q;
      default:              reg_rsp_o.error = reg_req_i.valid;
    endcase
  end

  // Strobes towards the FIFO and the command sequencer
  assign reg2hw_o.buffer_data_port.q  = reg_req_i.wdata;
  assign reg2hw_o.buffer_data_port.qe = wr & (offset == `SDHCI_BUFFER_DATA);
  assign reg2hw_o.buffer_data_port.re = rd & (offset == `SDHCI_BUFFER_DATA);
  assign reg2hw_o.command_index.q     = command_q[`SDHCI_CMD_IDX_MSB:`SDHCI_CMD_IDX_LSB];
  assign reg2hw_o.command_index.qe    = wr & (offset == `SDHCI_COMMAND);

  // ================================================
  // Storage
  // ================================================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      argument_q   <= '0;
      command_q    <= '0;
      int_enable_q <= '0;
    end else if (wr) begin
      if (offset == `SDHCI_ARGUMENT)   argument_q   <= reg_req_i.wdata;
      if (offset == `SDHCI_COMMAND)    command_q    <= reg_req_i.wdata;
      if (offset == `SDHCI_INT_ENABLE) int_enable_q <= reg_req_i.wdata;
    end
  end

  // Completion wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cmd_done_q <= 1'b0;
    end else if (hw2reg_i.command_complete) begin
      cmd_done_q <= 1'b1;
    end else if (wr && offset == `SDHCI_INT_STATUS &&
                 reg_req_i.wdata[`SDHCI_INT_CMD_COMPLETE]) begin
      cmd_done_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= |(int_status & int_enable_q);
    end
  end

  assign interrupt_o = irq_q;

  // The shared FIFO port sees at most one operation per access
  a_no_push_and_pop: assert property (@(posedge clk_i) disable iff (rst_i)
    !(reg2hw_o.buffer_data_port.qe && reg2hw_o.buffer_data_port.re));

endmodule

/* src/sram_shift_reg.sv */
/* Buffer Data Port FIFO
   Circular word buffer with a fill count and full/empty flags */

`timescale 1ns/1ps
`include "sdhci_consts.svh"

module sram_shift_reg #(
  parameter int DEPTH = `SDHCI_BUF_DEPTH,
  parameter int DW    = `SDHCI_DW
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          req_i,
  input  logic          we_i,          // 1 push, 0 pop
  input  logic [DW-1:0] write_data_i,
  output logic [DW-1:0] read_data_o,
  output logic          full_o,
  output logic          empty_o
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [DW-1:0] mem_q [DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          push;
  logic          pop;

  assign full_o  = (count_q == CW'(DEPTH));
  assign empty_o = (count_q == '0);

  // Push to full and pop from empty are dropped
  assign push = req_i & we_i & ~full_o;
  assign pop  = req_i & ~we_i & ~empty_o;

  assign read_data_o = empty_o ? '0 : mem_q[rd_ptr_q]; // Head word, same cycle

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= write_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  a_count_in_range: assert property (@(posedge clk_i) disable iff (rst_i)
    count_q <= CW'(DEPTH));

endmodule

/* src/sdhci_cmd_ctrl.sv */
/* Command sequencer
   Holds Command Inhibit (CMD) and signals completion after a fixed latency */

`timescale 1ns/1ps
`include "sdhci_consts.svh"

module sdhci_cmd_ctrl #(
  parameter int LATENCY = `SDHCI_CMD_LATENCY
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic cmd_issue_i,
  output logic inhibit_o,
  output logic cmd_complete_o
);

  localparam int CW = (LATENCY > 1) ? $clog2(LATENCY) : 1;

  logic          inhibit_q;
  logic [CW-1:0] cnt_q;   // Cycles since issue
  logic          start;

  assign start          = cmd_issue_i & ~inhibit_q; // Issue while busy is ignored
  assign cmd_complete_o = inhibit_q & (cnt_q == CW'(LATENCY - 1));
  assign inhibit_o      = inhibit_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      inhibit_q <= 1'b0;
      cnt_q     <= '0;
    end else if (start) begin
      inhibit_q <= 1'b1;
      cnt_q     <= '0;
    end else if (cmd_complete_o) begin
      inhibit_q <= 1'b0; // Falls on the completion edge
      cnt_q     <= '0;
    end else if (inhibit_q) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Completion ends the busy phase on the next edge
  a_complete_ends_inhibit: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_complete_o |-> inhibit_o ##1 !inhibit_o);

endmodule

/* src/user_sdhci.sv */
/* SD host controller register block, top level
   OBI adapter, SDHCI register file, data port FIFO and command sequencer */

`timescale 1ns/1ps

module user_sdhci (
  input  logic                clk_i,
  input  logic                rst_i,
  input  sdhci_pkg::obi_req_t obi_req_i,
  output sdhci_pkg::obi_rsp_t obi_rsp_o,
  output logic                interrupt_o
);

  sdhci_pkg::reg_req_t      reg_req;
  sdhci_pkg::reg_rsp_t      reg_rsp;
  sdhci_pkg::sdhci_reg2hw_t reg2hw;
  sdhci_pkg::sdhci_hw2reg_t hw2reg;

  logic [$bits(hw2reg.buffer_data_port.d)-1:0] fifo_rdata;
  logic                                        fifo_full;
  logic                                        fifo_empty;
  logic                                        cmd_inhibit;
  logic                                        cmd_complete;

  obi_to_reg i_obi_to_reg (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .obi_req_i (obi_req_i),
    .obi_rsp_o (obi_rsp_o),
    .reg_req_o (reg_req),
    .reg_rsp_i (reg_rsp)
  );

  sdhci_reg_file i_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .reg_req_i   (reg_req),
    .reg_rsp_o   (reg_rsp),
    .reg2hw_o    (reg2hw),
    .hw2reg_i    (hw2reg),
    .interrupt_o (interrupt_o)
  );

  // ================================================
  // Hardware behind the registers
  // ================================================
  sram_shift_reg i_buffer (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (reg2hw.buffer_data_port.re | reg2hw.buffer_data_port.qe),
    .we_i         (reg2hw.buffer_data_port.qe),
    .write_data_i (reg2hw.buffer_data_port.q),
    .read_data_o  (fifo_rdata),
    .full_o       (fifo_full),
    .empty_o      (fifo_empty)
  );

  sdhci_cmd_ctrl i_cmd_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .cmd_issue_i    (reg2hw.command_index.qe),
    .inhibit_o      (cmd_inhibit),
    .cmd_complete_o (cmd_complete)
  );

  always_comb begin
    hw2reg.buffer_data_port.d  = fifo_rdata;
    hw2reg.buffer_full         = fifo_full;
    hw2reg.buffer_empty        = fifo_empty;
    hw2reg.command_inhibit_cmd = cmd_inhibit;
    hw2reg.command_complete    = cmd_complete;
  end

endmodule

/* sim/tb_user_sdhci.sv */
/* Testbench for the SD host controller register block
   Drives OBI accesses and checks every answer against a model of the register map */

`timescale 1ns/1ps
`include "sdhci_consts.svh"

module tb_user_sdhci;

  localparam logic [31:0] BASE       = 32'h4000_1000;
  localparam int          MAX_CYCLES = 2000; // ~80 accesses of 2 cycles plus gaps, 10x margin

  logic                clk;
  logic                rst;
  sdhci_pkg::obi_req_t obi_req;
  sdhci_pkg::obi_rsp_t obi_rsp;
  logic                irq;

  int cycles;
  int n_checks;
  int n_errors;

  // Reference model state
  logic [31:0] ref_arg;
  logic [31:0] ref_cmd;
  logic [31:0] ref_en;
  logic        ref_done;  // Interrupt Status bit 0
  logic        ref_busy;  // Command inhibit
  int          ref_issue; // Edge that started the command
  logic [31:0] ref_fifo[$];

  user_sdhci DUT (
    .clk_i       (clk),
    .rst_i       (rst),
    .obi_req_i   (obi_req),
    .obi_rsp_o   (obi_rsp),
    .interrupt_o (irq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  // ==================================================
  // Reference model, one call per accepted access
  // ==================================================
  function automatic logic [31:0] ref_access(input logic we, input logic [7:0] off,
                                             input logic [31:0] wdata, input int acc_edge,
                                             output logic exp_err);
    logic [31:0] rd;
    rd      = '0;
    exp_err = 1'b0;
    // Completion lands LATENCY edges after the issuing edge
    if (ref_busy && acc_edge > ref_issue + `SDHCI_CMD_LATENCY) begin
      ref_busy = 1'b0;
      ref_done = 1'b1;
    end
    case (off)
      `SDHCI_ARGUMENT: begin
        if (we) ref_arg = wdata;
        rd = ref_arg;
      end
      `SDHCI_COMMAND: begin
        if (we && !ref_busy) begin
          ref_busy  = 1'b1;
          ref_issue = acc_edge;
        end
        if (we) ref_cmd = wdata;
        rd = ref_cmd;
      end
      `SDHCI_BUFFER_DATA: begin
        if (we && ref_fifo.size() < `SDHCI_BUF_DEPTH) ref_fifo.push_back(wdata);
        if (!we && ref_fifo.size() > 0) rd = ref_fifo.pop_front();
      end
      `SDHCI_PRESENT_STATE: begin
        rd[`SDHCI_PS_CMD_INHIBIT] = ref_busy;
        rd[`SDHCI_PS_BUF_WR_EN]   = ref_fifo.size() < `SDHCI_BUF_DEPTH;
        rd[`SDHCI_PS_BUF_RD_EN]   = ref_fifo.size() != 0;
      end
      `SDHCI_INT_STATUS: begin
        if (we && wdata[`SDHCI_INT_CMD_COMPLETE]) ref_done = 1'b0; // W1C
        rd[`SDHCI_INT_CMD_COMPLETE] = ref_done;
      end
      `SDHCI_INT_ENABLE: begin
        if (we) ref_en = wdata;
        rd = ref_en;
      end
      default: exp_err = 1'b1;
    endcase
    return rd;
  endfunction

  task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t ns: %s got 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // ==================================================
  // OBI driver
  // ==================================================
  task automatic obi_access(input logic we, input logic [7:0] off, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output int acc_edge);
    @(negedge clk);
    // Nothing in flight, so the port grants and shows no response
    check_equal("gnt while idle", obi_rsp.gnt, 1'b1);
    check_equal("rvalid while idle", obi_rsp.rvalid, 1'b0);
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.be    = '1;
    obi_req.addr  = {BASE[31:8], off};
    obi_req.wdata = wdata;
    while (!obi_rsp.gnt) @(negedge clk); // Accepted on the next rising edge
    @(negedge clk);
    acc_edge    = cycles;
    obi_req.req = 1'b0;
    // Response due one cycle after the accepting edge
    check_equal("rvalid after accept", obi_rsp.rvalid, 1'b1);
    check_equal("gnt while response pending", obi_rsp.gnt, 1'b0);
    while (!obi_rsp.rvalid) @(negedge clk);
    rdata = obi_rsp.rdata;
    err   = obi_rsp.err;
  endtask

  task automatic obi_write(input logic [7:0] off, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        err;
    logic        exp_err;
    int          acc_edge;
    obi_access(1'b1, off, wdata, rdata, err, acc_edge);
    void'(ref_access(1'b1, off, wdata, acc_edge, exp_err));
    check_equal($sformatf("write err at 0x%02h", off), err, exp_err);
  endtask

  task automatic obi_read(input logic [7:0] off, output logic [31:0] rdata);
    logic        err;
    logic        exp_err;
    logic [31:0] exp;
    int          acc_edge;
    obi_access(1'b0, off, '0, rdata, err, acc_edge);
    exp = ref_access(1'b0, off, '0, acc_edge, exp_err);
    check_equal($sformatf("read data at 0x%02h", off), rdata, exp);
    check_equal($sformatf("read err at 0x%02h", off), err, exp_err);
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    $display("Test %-16s %s (%0d errors)", name,
             (n_errors == errs_at_start) ? "ok" : "failed", n_errors - errs_at_start);
  endtask

  // ==================================================
  // Tests
  // ==================================================
  task automatic test_registers();
    logic [31:0] rdata;
    int          errs;
    errs = n_errors;
    obi_write(`SDHCI_ARGUMENT, $urandom());
    obi_write(`SDHCI_INT_ENABLE, $urandom());
    obi_read(`SDHCI_ARGUMENT, rdata);
    obi_read(`SDHCI_INT_ENABLE, rdata);
    obi_read(8'h10, rdata); // Unmapped
    report_test("registers", errs);
  endtask

  task automatic test_fifo(input int n_push, input int n_pop, input string name);
    logic [31:0] rdata;
    int          errs;
    errs = n_errors;
    repeat (n_push) begin
      obi_write(`SDHCI_BUFFER_DATA, $urandom());
      obi_read(`SDHCI_PRESENT_STATE, rdata);
    end
    repeat (n_pop) begin
      obi_read(`SDHCI_BUFFER_DATA, rdata);
      obi_read(`SDHCI_PRESENT_STATE, rdata);
    end
    report_test(name, errs);
  endtask

  task automatic test_command();
    logic [31:0] rdata;
    int          errs;
    errs = n_errors;
    obi_write(`SDHCI_COMMAND, 32'h0000_0800);
    obi_read(`SDHCI_PRESENT_STATE, rdata);
    check_equal("inhibit after issue", rdata[0], 1'b1);
    obi_write(`SDHCI_COMMAND, 32'h0000_1100); // Busy, must be dropped
    do obi_read(`SDHCI_PRESENT_STATE, rdata); while (rdata[0]);
    obi_read(`SDHCI_INT_STATUS, rdata);
    check_equal("complete status", rdata[0], 1'b1);
    obi_write(`SDHCI_INT_STATUS, 32'h1);
    repeat (3 * `SDHCI_CMD_LATENCY) @(negedge clk);
    obi_read(`SDHCI_INT_STATUS, rdata); // No second completion
    report_test("command", errs);
  endtask

  task automatic test_interrupt();
    logic [31:0] rdata;
    int          errs;
    errs = n_errors;
    obi_write(`SDHCI_INT_ENABLE, 32'h1);
    @(negedge clk);
    check_equal("irq idle", irq, ref_done & ref_en[0]);
    obi_write(`SDHCI_COMMAND, 32'h0000_0D00);
    do obi_read(`SDHCI_PRESENT_STATE, rdata); while (rdata[0]);
    @(negedge clk); // Interrupt line is registered
    check_equal("irq raised", irq, ref_done & ref_en[0]);
    obi_write(`SDHCI_INT_STATUS, 32'h1);
    @(negedge clk);
    check_equal("irq cleared", irq, ref_done & ref_en[0]);
    report_test("interrupt", errs);
  endtask

  initial begin
    void'($urandom(58));
    rst       = 1'b1;
    obi_req   = '0;
    ref_arg   = '0;
    ref_cmd   = '0;
    ref_en    = '0;
    ref_done  = 1'b0;
    ref_busy  = 1'b0;
    ref_issue = 0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    test_registers();
    test_fifo(5, 5, "fifo order");
    test_fifo(10, 9, "fifo limits"); // Last pop hits an empty FIFO
    test_command();
    test_interrupt();
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* user_sdhci.f */
+incdir+common
common/sdhci_pkg.sv
src/obi_to_reg.sv
sdhci_regs/sdhci_reg_file.sv
src/sram_shift_reg.sv
src/sdhci_cmd_ctrl.sv
src/user_sdhci.sv
sim/tb_user_sdhci.sv

/* Makefile */
# Verilator build and run for the SD host controller testbench

TOP := tb_user_sdhci

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f user_sdhci.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TB PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f user_sdhci.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
